/* core_pkg.sv */
package core_pkg;

    localparam int XLEN = 32;
    localparam int STRB_W = 4;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [STRB_W-1:0] wmask_t;
    typedef logic [4:0] reg_idx_t;

    localparam word_t RESET_PC = '0;

    // One-cycle command strobe towards memory
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } bus_cmd_t;

    // Sequencer states, one-hot
    typedef enum logic [3:0] {
        FETCH      = 4'b0001,
        WAIT_FETCH = 4'b0010,
        EXECUTE    = 4'b0100,
        WAIT_MEM   = 4'b1000
    } seq_state_t;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPCODE_ARITH_R = 7'b0110011,
        OPCODE_ARITH_I = 7'b0010011,
        OPCODE_BRANCH  = 7'b1100011,
        OPCODE_JAL     = 7'b1101111,
        OPCODE_JALR    = 7'b1100111,
        OPCODE_LOAD    = 7'b0000011,
        OPCODE_STORE   = 7'b0100011,
        OPCODE_LUI     = 7'b0110111,
        OPCODE_AUIPC   = 7'b0010111
    } opcode_t;

    // Arithmetic operations
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // Access size, bit 2 marks an unsigned load
    localparam logic [2:0] FUNCT3_BYTE = 3'b000;
    localparam logic [2:0] FUNCT3_HALF = 3'b001;
    localparam logic [2:0] FUNCT3_WORD = 3'b010;

    // SUB and arithmetic right shift
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word seen through each encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    function automatic logic [31:0] imm_i(instr_t ins);
        return {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    endfunction

    function automatic logic [31:0] imm_s(instr_t ins);
        return {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
    endfunction

    function automatic logic [31:0] imm_b(instr_t ins);
        return {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(instr_t ins);
        return {ins.u_fmt.imm_31_12, 12'h000};
    endfunction

    function automatic logic [31:0] imm_j(instr_t ins);
        return {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
    endfunction

endpackage

/* register_file.sv */
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
(
    input  logic     clk_in,
    input  logic     reset_in,
    input  logic     read_en,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t rd_idx,
    input  logic     write_en,
    input  word_t    write_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd_idx != '0)) begin
            // x0 never gets written and stays zero
            regs[rd_idx] <= write_data;
        end
    end

    // Operands are captured together with the instruction
    always_ff @(posedge clk_in) begin
        if (read_en) begin
            rs1_data <= regs[rs1_idx];
            rs2_data <= regs[rs2_idx];
        end
    end

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  instr_t instr,
    input  word_t  pc,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    output word_t  exec_result,
    output word_t  pc_next
);

    opcode_t    opcode;
    logic       is_arith_reg;
    logic       is_arith_imm;
    logic       is_branch;
    logic       alt_op;
    word_t      op_b;
    word_t      sum;
    logic [XLEN:0] diff_ext;
    word_t      diff;
    logic       borrow;
    logic       zero;
    logic       ovf;
    logic       less;
    logic [4:0] shamt;
    word_t      alu_result;
    word_t      pc_plus4;
    logic       taken;

    assign opcode = instr.r_fmt.opcode;
    assign is_arith_reg = (opcode == OPCODE_ARITH_R);
    assign is_arith_imm = (opcode == OPCODE_ARITH_I);
    assign is_branch = (opcode == OPCODE_BRANCH);
    assign alt_op = (instr.r_fmt.funct7 == FUNCT7_ALT);

    // Register operand for R-type and branches, I immediate for the rest
    assign op_b = (is_arith_reg || is_branch) ? rs2_data : imm_i(instr);
    assign sum = rs1_data + op_b;

    // Subtractor with flags, shared by SUB, SLT(U) and branches
    assign diff_ext = {1'b0, rs1_data} - {1'b0, op_b};
    assign diff = diff_ext[XLEN-1:0];
    assign borrow = diff_ext[XLEN];
    assign zero = (diff == '0);
    assign ovf = (rs1_data[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != rs1_data[XLEN-1]);
    assign less = diff[XLEN-1] ^ ovf;

    // Shift amount sits in the rs2 field for immediate shifts
    assign shamt = is_arith_imm ? instr.r_fmt.rs2 : rs2_data[4:0];

    always_comb begin
        case (instr.r_fmt.funct3)
            FUNCT3_ADD_SUB: alu_result = (is_arith_reg && alt_op) ? diff : sum;
            FUNCT3_SLL:     alu_result = rs1_data << shamt;
            FUNCT3_SLT:     alu_result = {{(XLEN-1){1'b0}}, less};
            FUNCT3_SLTU:    alu_result = {{(XLEN-1){1'b0}}, borrow};
            FUNCT3_XOR:     alu_result = rs1_data ^ op_b;
            FUNCT3_SRL_SRA: begin
                if (alt_op) begin
                    alu_result = $signed(rs1_data) >>> shamt;
                end else begin
                    alu_result = rs1_data >> shamt;
                end
            end
            FUNCT3_OR:      alu_result = rs1_data | op_b;
            default:        alu_result = rs1_data & op_b;
        endcase
    end

    always_comb begin
        case (instr.b_fmt.funct3)
            FUNCT3_BEQ:  taken = zero;
            FUNCT3_BNE:  taken = !zero;
            FUNCT3_BLT:  taken = less;
            FUNCT3_BGE:  taken = !less;
            FUNCT3_BLTU: taken = borrow;
            FUNCT3_BGEU: taken = !borrow;
            default:     taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + word_t'(4);

    always_comb begin
        case (opcode)
            OPCODE_LUI:   exec_result = imm_u(instr);
            OPCODE_AUIPC: exec_result = pc + imm_u(instr);
            OPCODE_JAL,
            OPCODE_JALR:  exec_result = pc_plus4;
            default:      exec_result = alu_result;
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_JAL:    pc_next = pc + imm_j(instr);
            // Target LSB is cleared as RV32I requires
            OPCODE_JALR:   pc_next = {sum[XLEN-1:1], 1'b0};
            OPCODE_BRANCH: pc_next = taken ? pc + imm_b(instr) : pc_plus4;
            default:       pc_next = pc_plus4;
        endcase
    end

endmodule

/* load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  instr_t instr,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    input  word_t  mem_rdata,
    output word_t  mem_addr,
    output word_t  wdata,
    output wmask_t wmask,
    output word_t  load_result
);

    logic       is_store;
    word_t      eff_addr;
    logic [1:0] lane;
    logic [2:0] funct3;
    logic       sign_ext;
    word_t      shifted;

    assign is_store = (instr.s_fmt.opcode == OPCODE_STORE);
    assign funct3 = instr.i_fmt.funct3;
    assign sign_ext = !funct3[2];

    assign eff_addr = rs1_data + (is_store ? imm_s(instr) : imm_i(instr));

    // Bus is word addressed, low bits pick the byte lane
    assign mem_addr = {eff_addr[XLEN-1:2], 2'b00};
    assign lane = eff_addr[1:0];

    // Replicating the source puts it into every lane, the mask picks the right one
    always_comb begin
        wdata = rs2_data;
        wmask = '1;
        if (is_store) begin
            case (funct3[1:0])
                FUNCT3_BYTE[1:0]: begin
                    wdata = {STRB_W{rs2_data[7:0]}};
                    wmask = wmask_t'(1) << lane;
                end
                FUNCT3_HALF[1:0]: begin
                    wdata = {2{rs2_data[15:0]}};
                    wmask = lane[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    wdata = rs2_data;
                    wmask = '1;
                end
            endcase
        end
    end

    // Move the addressed lane down to bit 0
    assign shifted = mem_rdata >> {lane, 3'b000};

    always_comb begin
        case (funct3[1:0])
            FUNCT3_BYTE[1:0]: begin
                load_result = {{(XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
            end
            FUNCT3_HALF[1:0]: begin
                load_result = {{(XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
            end
            FUNCT3_WORD[1:0]: begin
                load_result = mem_rdata;
            end
            default: begin
                load_result = mem_rdata;
            end
        endcase
    end

endmodule

/* core_sequencer.sv */
`timescale 1ns/1ps

module core_sequencer
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic     clk_in,
    input  logic     reset_in,
    input  logic     mem_busy,
    input  word_t    mem_rdata,
    input  word_t    exec_result,
    input  word_t    pc_next,
    input  word_t    lsu_addr,
    input  word_t    load_result,
    output instr_t   instr,
    output word_t    pc,
    output bus_cmd_t mem_cmd,
    output word_t    mem_addr,
    output logic     reg_read_en,
    output logic     reg_write_en,
    output word_t    write_data
);

    seq_state_t state;
    opcode_t    opcode;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       fetch_done;
    logic       mem_done;

    assign opcode = instr.r_fmt.opcode;
    assign is_load = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);
    assign is_branch = (opcode == OPCODE_BRANCH);

    assign fetch_done = (state == WAIT_FETCH) && !mem_busy;
    assign mem_done = (state == WAIT_MEM) && !mem_busy;

    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state <= FETCH;
            pc <= RESET_PC;
        end else begin
            case (state)
                FETCH: state <= WAIT_FETCH;
                WAIT_FETCH: begin
                    if (!mem_busy) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    pc <= pc_next;
                    state <= (is_load || is_store) ? WAIT_MEM : FETCH;
                end
                WAIT_MEM: begin
                    if (!mem_busy) begin
                        state <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // Instruction register, loaded when the fetch completes
    always_ff @(posedge clk_in) begin
        if (fetch_done) begin
            instr <= mem_rdata;
        end
    end

    assign reg_read_en = fetch_done;

    // Commands only leave in FETCH and EXECUTE
    always_comb begin
        case (state)
            FETCH:   mem_cmd = LOAD;
            EXECUTE: mem_cmd = is_load ? LOAD : (is_store ? STORE : NONE);
            default: mem_cmd = NONE;
        endcase
    end

    assign mem_addr = (state == FETCH) ? pc : lsu_addr;

    // Loads write when their data arrives, stores and branches never write
    assign reg_write_en = ((state == EXECUTE) && !is_load && !is_store && !is_branch)
                        || (mem_done && is_load);
    assign write_data = (state == WAIT_MEM) ? load_result : exec_result;

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic     clk_in,
    input  logic     reset_in,
    input  word_t    mem_rdata,
    input  logic     mem_busy,
    output bus_cmd_t mem_cmd,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output wmask_t   mem_wmask
);

    instr_t instr;
    instr_t fetch_word;
    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  exec_result;
    word_t  pc_next;
    word_t  lsu_addr;
    word_t  load_result;
    word_t  write_data;
    logic   reg_read_en;
    logic   reg_write_en;

    // Source indices come straight off the bus while the instruction is latched
    assign fetch_word = mem_rdata;

    core_sequencer u_seq (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .mem_busy     (mem_busy),
        .mem_rdata    (mem_rdata),
        .exec_result  (exec_result),
        .pc_next      (pc_next),
        .lsu_addr     (lsu_addr),
        .load_result  (load_result),
        .instr        (instr),
        .pc           (pc),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .reg_read_en  (reg_read_en),
        .reg_write_en (reg_write_en),
        .write_data   (write_data)
    );

    register_file u_regs (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .read_en    (reg_read_en),
        .rs1_idx    (fetch_word.r_fmt.rs1),
        .rs2_idx    (fetch_word.r_fmt.rs2),
        .rd_idx     (instr.r_fmt.rd),
        .write_en   (reg_write_en),
        .write_data (write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    exec_unit u_exec (
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exec_result (exec_result),
        .pc_next     (pc_next)
    );

    load_store_unit u_lsu (
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .mem_rdata   (mem_rdata),
        .mem_addr    (lsu_addr),
        .wdata       (mem_wdata),
        .wmask       (mem_wmask),
        .load_result (load_result)
    );

endmodule

/* rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker
    import core_pkg::*;
(
    input logic     clk_in,
    input logic     reset_in,
    input bus_cmd_t mem_cmd,
    input word_t    mem_addr,
    input wmask_t   mem_wmask
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Commands are single-cycle strobes
    cmd_single_cycle: assert property (@(posedge clk_in)
        (reset_in && $past(reset_in) && mem_cmd != NONE) |=> (mem_cmd == NONE))
        else begin
            $error("memory command repeated in the following cycle");
            fail_count++;
        end

    addr_word_aligned: assert property (@(posedge clk_in)
        reset_in |-> (mem_addr[1:0] == 2'b00))
        else begin
            $error("mem_addr is not word aligned");
            fail_count++;
        end

    store_has_lanes: assert property (@(posedge clk_in)
        (reset_in && mem_cmd == STORE) |-> (mem_wmask != '0))
        else begin
            $error("store issued with an empty byte mask");
            fail_count++;
        end

    // First cycle out of reset fetches from the reset vector
    first_cmd_fetch: assert property (@(posedge clk_in)
        (reset_in && !$past(reset_in)) |-> (mem_cmd == LOAD && mem_addr == '0))
        else begin
            $error("first command after reset is not a fetch at address 0");
            fail_count++;
        end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core
    import core_pkg::*;
    import rv_isa_pkg::*;
();

    localparam word_t SEED        = 32'h8c1dab75;
    localparam int    TIMEOUT     = 200;
    localparam int    MAX_ROWS    = 128;
    localparam word_t DATA_A      = 32'h0000_0200;
    localparam word_t DATA_B      = 32'h0000_0204;
    localparam word_t LOAD_BASE   = 32'h0000_0300;
    localparam word_t LOAD_WORD   = 32'h8ea5_9261;
    localparam word_t RESULT_ADDR = 32'h0000_03f0;
    // Address of the instruction under test in every program
    localparam word_t PC_UT       = 32'h0000_0008;

    logic     clk_in;
    logic     reset_in;
    word_t    mem_rdata;
    logic     mem_busy;
    bus_cmd_t mem_cmd;
    word_t    mem_addr;
    word_t    mem_wdata;
    wmask_t   mem_wmask;

    word_t mem [1024];
    word_t merged;
    word_t rng;
    int    wait_left;
    int    value_errors;
    int    timeout_errors;
    int    row_count;
    logic [11:0] imm_val;

    // Test table
    instr_t     tab_ins  [MAX_ROWS];
    word_t      tab_a    [MAX_ROWS];
    word_t      tab_b    [MAX_ROWS];
    logic [2:0] tab_kind [MAX_ROWS];
    logic [1:0] tab_off  [MAX_ROWS];
    word_t      tab_word [MAX_ROWS];
    wmask_t     tab_mask [MAX_ROWS];

    // Signed and unsigned edge operands
    word_t      edge_a   [3] = '{32'h8000_0000, 32'hffff_fff3, 32'h7fff_ffff};
    word_t      edge_b   [3] = '{32'h7fff_ffff, 32'h0000_0004, 32'h8000_0001};
    logic [11:0] edge_imm [3] = '{12'h800, 12'h7ff, 12'hffd};
    // Pairs chosen so every branch sees both outcomes
    word_t      br_a     [3] = '{32'd5, 32'hffff_ffff, 32'd1};
    word_t      br_b     [3] = '{32'd5, 32'd1, 32'hffff_ffff};

    rv_core UUT (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask)
    );

    bind rv_core rv_core_checker u_checker (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wmask (mem_wmask)
    );

    always #2 clk_in = ~clk_in;

    function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3, reg_idx_t rd);
        instr_t ins;
        ins.r_fmt = {f7, rs2, rs1, f3, rd, OPCODE_ARITH_R};
        return ins;
    endfunction

    function automatic instr_t i_type(opcode_t op, logic [11:0] imm, reg_idx_t rs1,
                                      logic [2:0] f3, reg_idx_t rd);
        instr_t ins;
        ins.i_fmt = {imm, rs1, f3, rd, op};
        return ins;
    endfunction

    function automatic instr_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3);
        instr_t ins;
        ins.s_fmt = {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
        return ins;
    endfunction

    function automatic instr_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                      logic [2:0] f3);
        instr_t ins;
        ins.b_fmt = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
        return ins;
    endfunction

    function automatic instr_t u_type(opcode_t op, logic [19:0] imm, reg_idx_t rd);
        instr_t ins;
        ins.u_fmt = {imm, rd, op};
        return ins;
    endfunction

    function automatic instr_t j_type(logic [20:0] imm, reg_idx_t rd);
        instr_t ins;
        ins.j_fmt = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
        return ins;
    endfunction

    function automatic word_t xorshift(word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte mask expanded to a bit mask
    function automatic word_t lane_bits(wmask_t m);
        word_t w;
        for (int i = 0; i < STRB_W; i++) begin
            w[8*i +: 8] = {8{m[i]}};
        end
        return w;
    endfunction

    // Value that x3 holds when the program reaches its store
    function automatic word_t ref_value(instr_t ins, word_t a, word_t b);
        word_t imm;
        word_t op2;
        word_t sra;
        word_t ea;
        word_t lw;
        logic  taken;
        imm = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
        op2 = (ins.r_fmt.opcode == OPCODE_ARITH_R) ? b : imm;
        sra = $signed(a) >>> op2[4:0];
        ea = a + imm;
        lw = LOAD_WORD >> (8 * ea[1:0]);
        case (ins.r_fmt.opcode)
            OPCODE_ARITH_R, OPCODE_ARITH_I: begin
                case (ins.r_fmt.funct3)
                    FUNCT3_ADD_SUB: begin
                        if (ins.r_fmt.opcode == OPCODE_ARITH_R && ins.r_fmt.funct7[5]) begin
                            return a - op2;
                        end
                        return a + op2;
                    end
                    FUNCT3_SLL:     return a << op2[4:0];
                    FUNCT3_SLT:     return ($signed(a) < $signed(op2)) ? 1 : 0;
                    FUNCT3_SLTU:    return (a < op2) ? 1 : 0;
                    FUNCT3_XOR:     return a ^ op2;
                    FUNCT3_SRL_SRA: return ins.r_fmt.funct7[5] ? sra : (a >> op2[4:0]);
                    FUNCT3_OR:      return a | op2;
                    default:        return a & op2;
                endcase
            end
            OPCODE_BRANCH: begin
                case (ins.b_fmt.funct3)
                    FUNCT3_BEQ:  taken = (a == b);
                    FUNCT3_BNE:  taken = (a != b);
                    FUNCT3_BLT:  taken = ($signed(a) < $signed(b));
                    FUNCT3_BGE:  taken = ($signed(a) >= $signed(b));
                    FUNCT3_BLTU: taken = (a < b);
                    default:     taken = (a >= b);
                endcase
                // The skipped ADDI sets x3 to 1 only on fall-through
                return taken ? 0 : 1;
            end
            OPCODE_JAL, OPCODE_JALR: return PC_UT + 4;
            OPCODE_LUI:   return {ins.u_fmt.imm_31_12, 12'h000};
            OPCODE_AUIPC: return PC_UT + {ins.u_fmt.imm_31_12, 12'h000};
            default: begin
                case (ins.i_fmt.funct3)
                    3'b000:  return {{24{lw[7]}}, lw[7:0]};
                    3'b100:  return {24'h0, lw[7:0]};
                    3'b001:  return {{16{lw[15]}}, lw[15:0]};
                    3'b101:  return {16'h0, lw[15:0]};
                    default: return LOAD_WORD;
                endcase
            end
        endcase
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_mask(string name, wmask_t expected, wmask_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_cmd(string name, bus_cmd_t expected, bus_cmd_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Expected lanes follow the RV32I little-endian store rule
    task automatic add_row(instr_t ins, word_t a, word_t b, logic [2:0] kind, logic [1:0] off);
        word_t v;
        v = ref_value(ins, a, b);
        tab_ins[row_count] = ins;
        tab_a[row_count] = a;
        tab_b[row_count] = b;
        tab_kind[row_count] = kind;
        tab_off[row_count] = off;
        case (kind)
            FUNCT3_BYTE: begin
                tab_mask[row_count] = 4'b0001 << off;
                tab_word[row_count] = {24'h0, v[7:0]} << (8 * off);
            end
            FUNCT3_HALF: begin
                tab_mask[row_count] = 4'b0011 << off;
                tab_word[row_count] = {16'h0, v[15:0]} << (8 * off);
            end
            default: begin
                tab_mask[row_count] = 4'b1111;
                tab_word[row_count] = v;
            end
        endcase
        row_count++;
    endtask

    task automatic run_row(int r);
        logic found;
        @(posedge clk_in);
        reset_in <= 1'b0;
        @(posedge clk_in);
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5a5a_0000 ^ i;
        end
        mem[0] = i_type(OPCODE_LOAD, DATA_A[11:0], 0, FUNCT3_WORD, 1);
        mem[1] = i_type(OPCODE_LOAD, DATA_B[11:0], 0, FUNCT3_WORD, 2);
        mem[2] = tab_ins[r];
        // Slot 12 is the skipped ADDI for branches, otherwise a write attempt to x0
        if (tab_ins[r].r_fmt.opcode == OPCODE_BRANCH) begin
            mem[3] = i_type(OPCODE_ARITH_I, 12'd1, 0, FUNCT3_ADD_SUB, 3);
        end else begin
            mem[3] = i_type(OPCODE_ARITH_I, 12'h123, 1, FUNCT3_ADD_SUB, 0);
        end
        // Store based on x0, so a corrupted x0 moves the store away
        mem[4] = s_type(RESULT_ADDR[11:0] + tab_off[r], 3, 0, tab_kind[r]);
        mem[5] = j_type(21'd0, 0);
        mem[DATA_A[11:2]] = tab_a[r];
        mem[DATA_B[11:2]] = tab_b[r];
        mem[LOAD_BASE[11:2]] = LOAD_WORD;
        repeat (4) @(posedge clk_in);
        reset_in <= 1'b1;
        @(negedge clk_in);
        check_cmd("mem_cmd", LOAD, mem_cmd);
        check_word("mem_addr", RESET_PC, mem_addr);
        found = 1'b0;
        for (int c = 0; c < TIMEOUT && !found; c++) begin
            @(negedge clk_in);
            found = (mem_cmd == STORE) && (mem_addr == RESULT_ADDR);
        end
        if (!found) begin
            $display("Timeout: row %0d never stored its result to %h", r, RESULT_ADDR);
            timeout_errors++;
        end else begin
            check_mask("mem_wmask", tab_mask[r], mem_wmask);
            check_word("mem_wdata", tab_word[r] & lane_bits(tab_mask[r]),
                       mem_wdata & lane_bits(tab_mask[r]));
        end
    endtask

    // Memory with 0 to 3 random busy cycles per access
    always @(posedge clk_in) begin
        if (!reset_in) begin
            mem_busy <= 1'b0;
            wait_left <= 0;
        end else if (mem_cmd != NONE) begin
            if (mem_cmd == STORE) begin
                merged = mem[mem_addr[11:2]];
                for (int i = 0; i < STRB_W; i++) begin
                    if (mem_wmask[i]) begin
                        merged[8*i +: 8] = mem_wdata[8*i +: 8];
                    end
                end
                mem[mem_addr[11:2]] <= merged;
            end
            rng = xorshift(rng);
            mem_rdata <= mem[mem_addr[11:2]];
            wait_left <= rng % 4;
            mem_busy <= (rng % 4) != 0;
        end else if (wait_left != 0) begin
            wait_left <= wait_left - 1;
            mem_busy <= wait_left > 1;
        end
    end

    initial begin
        clk_in = 1'b0;
        reset_in = 1'b0;
        mem_rdata = '0;
        mem_busy = 1'b0;
        rng = SEED;
        value_errors = 0;
        timeout_errors = 0;
        row_count = 0;

        // Register and immediate arithmetic
        for (int p = 0; p < 3; p++) begin
            for (int f = 0; f < 8; f++) begin
                add_row(r_type(7'd0, 2, 1, 3'(f), 3), edge_a[p], edge_b[p], FUNCT3_WORD, 0);
                imm_val = (f == 1 || f == 5) ? (edge_imm[p] & 12'h01f) : edge_imm[p];
                add_row(i_type(OPCODE_ARITH_I, imm_val, 1, 3'(f), 3), edge_a[p], 0,
                        FUNCT3_WORD, 0);
            end
            add_row(r_type(FUNCT7_ALT, 2, 1, FUNCT3_ADD_SUB, 3), edge_a[p], edge_b[p],
                    FUNCT3_WORD, 0);
            add_row(r_type(FUNCT7_ALT, 2, 1, FUNCT3_SRL_SRA, 3), edge_a[p], edge_b[p],
                    FUNCT3_WORD, 0);
            add_row(i_type(OPCODE_ARITH_I, 12'h400 | (edge_imm[p] & 12'h01f), 1,
                           FUNCT3_SRL_SRA, 3), edge_a[p], 0, FUNCT3_WORD, 0);
        end

        // Branches jump over slot 12 to the store
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int p = 0; p < 3; p++) begin
                    add_row(b_type(13'd8, 2, 1, 3'(f)), br_a[p], br_b[p], FUNCT3_WORD, 0);
                end
            end
        end

        // Jumps land on the store at 16, JALR also clears the target LSB
        add_row(j_type(21'd8, 3), 0, 0, FUNCT3_WORD, 0);
        add_row(i_type(OPCODE_JALR, 12'd4, 1, 3'b000, 3), 32'd13, 0, FUNCT3_WORD, 0);
        add_row(u_type(OPCODE_LUI, 20'hfedcb, 3), 0, 0, FUNCT3_WORD, 0);
        add_row(u_type(OPCODE_AUIPC, 20'h80001, 3), 0, 0, FUNCT3_WORD, 0);

        // Loads with a negative offset from x1
        for (int off = 0; off < 4; off++) begin
            add_row(i_type(OPCODE_LOAD, 12'(off - 8), 1, 3'b000, 3), LOAD_BASE + 8, 0,
                    FUNCT3_WORD, 0);
            add_row(i_type(OPCODE_LOAD, 12'(off - 8), 1, 3'b100, 3), LOAD_BASE + 8, 0,
                    FUNCT3_WORD, 0);
            if (off % 2 == 0) begin
                add_row(i_type(OPCODE_LOAD, 12'(off - 8), 1, 3'b001, 3), LOAD_BASE + 8, 0,
                        FUNCT3_WORD, 0);
                add_row(i_type(OPCODE_LOAD, 12'(off - 8), 1, 3'b101, 3), LOAD_BASE + 8, 0,
                        FUNCT3_WORD, 0);
            end
        end
        add_row(i_type(OPCODE_LOAD, 12'hff8, 1, FUNCT3_WORD, 3), LOAD_BASE + 8, 0,
                FUNCT3_WORD, 0);

        // Byte and halfword stores in every legal lane
        for (int off = 0; off < 4; off++) begin
            add_row(r_type(7'd0, 2, 1, FUNCT3_ADD_SUB, 3), 32'h8899_aabb, 32'h1122_3344,
                    FUNCT3_BYTE, 2'(off));
            if (off % 2 == 0) begin
                add_row(r_type(7'd0, 2, 1, FUNCT3_ADD_SUB, 3), 32'h8899_aabb, 32'h1122_3344,
                        FUNCT3_HALF, 2'(off));
            end
        end

        for (int r = 0; r < row_count; r++) begin
            run_row(r);
        end

        $display("Finished %0d rows: %0d value errors, %0d timeouts, %0d assertion failures",
                 row_count, value_errors, timeout_errors, UUT.u_checker.fail_count);
        if (value_errors == 0 && timeout_errors == 0 && UUT.u_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
core_pkg.sv
rv_isa_pkg.sv
register_file.sv
exec_unit.sv
load_store_unit.sv
core_sequencer.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - core_pkg.sv
  - rv_isa_pkg.sv
  - register_file.sv
  - exec_unit.sv
  - load_store_unit.sv
  - core_sequencer.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_core_checker.sv
      - tb_rv_core.sv
